// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;

	// byte address, wide enough to reach the i/o window at 0x30000
	typedef logic [17:0] addr_t;

	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;

	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		SEQ_FETCH,
		SEQ_DECODE,
		SEQ_EXECUTE,
		SEQ_MEM,
		SEQ_WRITEBACK
	} seq_state_t;

	// mem_a[17:16] both set selects i/o
	localparam logic [31:0] IO_BASE      = 32'h0003_0000;
	localparam logic [31:0] IO_OUT_ADDR  = 32'h0003_0000;
	localparam logic [31:0] IO_STOP_ADDR = 32'h0003_0004;

endpackage

`default_nettype wire

// File: core/alu.sv
`default_nettype none

module alu import cpu_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output logic    equal
);

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_XOR:    result = a ^ b;
			ALU_PASS_B: result = b;
			default:    result = a + b;
		endcase
	end

	// branch condition, independent of op
	assign equal = (a == b);

endmodule

`default_nettype wire

// File: core/regfile.sv
`default_nettype none

module regfile import cpu_pkg::*; (
	input  logic     clk_in,
	input  logic     reset,
	input  logic     rdy_in,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	output word_t    rdata1,
	output word_t    rdata2,
	input  logic     we,
	input  reg_idx_t waddr,
	input  word_t    wdata
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk_in) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rdy_in && we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: core/decoder.sv
`default_nettype none

module decoder import cpu_pkg::*; (
	input  word_t    instr,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output reg_idx_t rd,
	output word_t    imm,
	output alu_op_t  alu_op,
	output logic     use_imm,
	output logic     is_load,
	output logic     is_store,
	output logic     is_branch,
	output logic     is_jal,
	output logic     is_lui,
	output logic     writes_rd,
	output logic     branch_ne
);

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	alu_op_t    f3_op;
	logic       f3_ok;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rd     = instr[11:7];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// funct3 map shared by register and immediate forms
	always_comb begin
		f3_ok = 1'b1;
		case (funct3)
			3'b000: f3_op = ALU_ADD;
			3'b100: f3_op = ALU_XOR;
			3'b110: f3_op = ALU_OR;
			3'b111: f3_op = ALU_AND;
			default: begin
				f3_op = ALU_ADD;
				f3_ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		imm       = '0;
		alu_op    = ALU_ADD;
		use_imm   = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		is_lui    = 1'b0;
		writes_rd = 1'b0;
		branch_ne = 1'b0;
		case (opcode)
			OP_LUI: begin
				imm       = imm_u;
				alu_op    = ALU_PASS_B;
				use_imm   = 1'b1;
				is_lui    = 1'b1;
				writes_rd = 1'b1;
			end
			OP_IMM: begin
				imm       = imm_i;
				alu_op    = f3_op;
				use_imm   = 1'b1;
				writes_rd = f3_ok;
			end
			OP_REG: begin
				// funct7 0x20 is only legal as sub
				if (f3_ok && (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000))) begin
					alu_op    = funct7[5] ? ALU_SUB : f3_op;
					writes_rd = 1'b1;
				end
			end
			OP_LOAD: begin
				imm       = imm_i;
				use_imm   = 1'b1;
				is_load   = (funct3 == 3'b010);
				writes_rd = (funct3 == 3'b010);
			end
			OP_STORE: begin
				imm      = imm_s;
				use_imm  = 1'b1;
				is_store = (funct3 == 3'b010);
			end
			OP_BRANCH: begin
				imm       = imm_b;
				alu_op    = ALU_SUB;
				is_branch = (funct3 == 3'b000 || funct3 == 3'b001);
				branch_ne = (funct3 == 3'b001);
			end
			OP_JAL: begin
				imm       = imm_j;
				is_jal    = 1'b1;
				writes_rd = 1'b1;
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: core/mem_ctrl.sv
`default_nettype none

module mem_ctrl import cpu_pkg::*; (
	input  logic        clk_in,
	input  logic        reset,
	input  logic        rdy_in,
	input  logic        req_rd,
	input  logic        req_wr,
	input  addr_t       req_addr,
	input  word_t       req_wdata,
	output logic        done,
	output word_t       rdata,
	input  logic [7:0]  mem_din,
	output logic [7:0]  mem_dout,
	output logic [31:0] mem_a,
	output logic        mem_wr
);

	logic        busy;
	logic        writing;
	logic [2:0]  step;
	addr_t       byte_addr;
	logic [7:0]  dout_q;
	logic [23:0] shift_q;
	logic        last;
	logic        start;

	// a write ends on its fourth byte, a read one cycle later when byte 3 arrives
	assign last  = busy && (writing ? (step == 3'd4) : (step == 3'd5));
	assign done  = last && rdy_in;

	// a new request may follow directly on the finishing cycle
	assign start = (req_rd || req_wr) && (!busy || last);

	// byte 3 is still on the bus when done is raised
	assign rdata    = {mem_din, shift_q};
	assign mem_a    = {14'b0, byte_addr};
	assign mem_dout = dout_q;
	assign mem_wr   = writing && rdy_in;

	always_ff @(posedge clk_in) begin
		if (reset) begin
			busy      <= 1'b0;
			writing   <= 1'b0;
			step      <= 3'd0;
			byte_addr <= '0;
			dout_q    <= 8'h00;
		end else if (rdy_in) begin
			if (start) begin
				busy      <= 1'b1;
				writing   <= req_wr;
				step      <= 3'd1;
				byte_addr <= req_addr;
				if (req_wr) begin
					dout_q <= req_wdata[7:0];
				end
			end else if (last) begin
				busy    <= 1'b0;
				writing <= 1'b0;
			end else if (busy) begin
				step <= step + 3'd1;
				// four addresses, offsets 0 to 3
				if (step < 3'd4) begin
					byte_addr <= byte_addr + 18'd1;
				end
				if (writing) begin
					dout_q <= shift_q[7:0];
				end
			end
		end
	end

	// shared byte shifter, write bytes go out low first, read bytes come in low first
	always_ff @(posedge clk_in) begin
		if (rdy_in) begin
			if (start && req_wr) begin
				shift_q <= req_wdata[31:8];
			end else if (busy && !last) begin
				if (writing) begin
					shift_q <= {8'h00, shift_q[23:8]};
				end else if (step >= 3'd2) begin
					shift_q <= {mem_din, shift_q[23:8]};
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: core/sequencer.sv
`default_nettype none

module sequencer import cpu_pkg::*; #(
	parameter addr_t RESET_PC = '0
) (
	input  logic     clk_in,
	input  logic     reset,
	input  logic     rdy_in,
	output word_t    instr,
	input  word_t    rd_data2,
	input  word_t    alu_result,
	input  logic     alu_equal,
	input  word_t    imm,
	input  reg_idx_t rd,
	input  logic     is_load,
	input  logic     is_store,
	input  logic     is_branch,
	input  logic     is_jal,
	input  logic     is_lui,
	input  logic     writes_rd,
	input  logic     branch_ne,
	output logic     req_rd,
	output logic     req_wr,
	output addr_t    req_addr,
	output word_t    req_wdata,
	input  logic     done,
	input  word_t    rdata,
	output logic     we,
	output reg_idx_t waddr,
	output word_t    wdata
);

	seq_state_t state;
	addr_t      pc;
	word_t      result;
	logic       issued;
	logic       fetch_req;
	logic       taken;
	addr_t      pc_plus4;
	addr_t      pc_target;
	word_t      exec_value;

	assign pc_plus4  = pc + 18'd4;
	assign pc_target = pc + imm[17:0];

	// beq takes the branch on equal, bne on not equal
	assign taken = is_jal || (is_branch && (alu_equal != branch_ne));

	// the next fetch is requested from the last cycle of the current instruction
	assign fetch_req = (state == SEQ_FETCH && !issued) ||
		(state == SEQ_WRITEBACK) ||
		(state == SEQ_MEM && done && is_store);

	assign req_rd    = fetch_req || (state == SEQ_EXECUTE && is_load);
	assign req_wr    = (state == SEQ_EXECUTE) && is_store;
	assign req_addr  = (state == SEQ_EXECUTE) ? alu_result[17:0] : pc;
	assign req_wdata = rd_data2;

	assign we    = (state == SEQ_WRITEBACK) && writes_rd;
	assign waddr = rd;
	assign wdata = result;

	always_comb begin
		if (is_jal) begin
			exec_value = {14'b0, pc_plus4};
		end else if (is_lui) begin
			exec_value = imm;
		end else begin
			exec_value = alu_result;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			state  <= SEQ_FETCH;
			pc     <= RESET_PC;
			issued <= 1'b0;
		end else if (rdy_in) begin
			case (state)
				SEQ_FETCH: begin
					if (done) begin
						state  <= SEQ_DECODE;
						issued <= 1'b0;
					end else if (!issued) begin
						issued <= 1'b1;
					end
				end
				SEQ_DECODE: begin
					state <= SEQ_EXECUTE;
				end
				SEQ_EXECUTE: begin
					pc    <= taken ? pc_target : pc_plus4;
					state <= (is_load || is_store) ? SEQ_MEM : SEQ_WRITEBACK;
				end
				SEQ_MEM: begin
					if (done) begin
						// a store has nothing to write back
						if (is_store) begin
							state  <= SEQ_FETCH;
							issued <= 1'b1;
						end else begin
							state <= SEQ_WRITEBACK;
						end
					end
				end
				SEQ_WRITEBACK: begin
					state  <= SEQ_FETCH;
					issued <= 1'b1;
				end
				default: begin
					state <= SEQ_FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (rdy_in) begin
			if (state == SEQ_FETCH && done) begin
				instr <= rdata;
			end
			if (state == SEQ_EXECUTE) begin
				result <= exec_value;
			end
			if (state == SEQ_MEM && done) begin
				result <= rdata;
			end
		end
	end

endmodule

`default_nettype wire

// File: core/cpu.sv
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter addr_t RESET_PC = '0
) (
	input  logic        clk_in,
	input  logic        reset,
	input  logic        rdy_in,
	input  logic [7:0]  mem_din,
	output logic [7:0]  mem_dout,
	output logic [31:0] mem_a,
	output logic        mem_wr
);

	word_t    instr;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t    imm;
	alu_op_t  alu_op;
	logic     use_imm;
	logic     is_load;
	logic     is_store;
	logic     is_branch;
	logic     is_jal;
	logic     is_lui;
	logic     writes_rd;
	logic     branch_ne;

	word_t    rd_data1;
	word_t    rd_data2;
	word_t    alu_b;
	word_t    alu_result;
	logic     alu_equal;

	logic     we;
	reg_idx_t waddr;
	word_t    wdata;

	logic     req_rd;
	logic     req_wr;
	addr_t    req_addr;
	word_t    req_wdata;
	logic     done;
	word_t    rdata;

	// immediate forms replace rs2 as the second operand
	assign alu_b = use_imm ? imm : rd_data2;

	sequencer #(.RESET_PC(RESET_PC)) seq0 (
		.clk_in(clk_in), .reset(reset), .rdy_in(rdy_in),
		.instr(instr), .rd_data2(rd_data2),
		.alu_result(alu_result), .alu_equal(alu_equal), .imm(imm), .rd(rd),
		.is_load(is_load), .is_store(is_store), .is_branch(is_branch),
		.is_jal(is_jal), .is_lui(is_lui), .writes_rd(writes_rd), .branch_ne(branch_ne),
		.req_rd(req_rd), .req_wr(req_wr), .req_addr(req_addr), .req_wdata(req_wdata),
		.done(done), .rdata(rdata),
		.we(we), .waddr(waddr), .wdata(wdata)
	);

	decoder dec0 (
		.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.alu_op(alu_op), .use_imm(use_imm),
		.is_load(is_load), .is_store(is_store), .is_branch(is_branch),
		.is_jal(is_jal), .is_lui(is_lui), .writes_rd(writes_rd), .branch_ne(branch_ne)
	);

	alu alu0 (
		.op(alu_op), .a(rd_data1), .b(alu_b),
		.result(alu_result), .equal(alu_equal)
	);

	regfile regfile0 (
		.clk_in(clk_in), .reset(reset), .rdy_in(rdy_in),
		.raddr1(rs1), .raddr2(rs2), .rdata1(rd_data1), .rdata2(rd_data2),
		.we(we), .waddr(waddr), .wdata(wdata)
	);

	mem_ctrl mem_ctrl0 (
		.clk_in(clk_in), .reset(reset), .rdy_in(rdy_in),
		.req_rd(req_rd), .req_wr(req_wr), .req_addr(req_addr), .req_wdata(req_wdata),
		.done(done), .rdata(rdata),
		.mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
	);

endmodule

`default_nettype wire

// File: tb/ram_model.sv
`default_nettype none

module ram_model import cpu_pkg::*; (
	input  logic        clk_in,
	input  logic        rdy_in,
	input  logic [31:0] mem_a,
	input  logic [7:0]  mem_dout,
	input  logic        mem_wr,
	output logic [7:0]  mem_din,
	output logic        out_valid,
	output logic [7:0]  out_byte,
	output logic        stopped
);
	timeunit 1ns;
	timeprecision 1ps;

	// 128 KB of byte storage, addressed by mem_a[16:0]
	logic [7:0] mem [0:131071];
	logic       is_io;

	assign is_io = ((mem_a & IO_BASE) == IO_BASE);

	initial begin
		// fill pattern mixes all 17 address bits
		for (int i = 0; i < 131072; i++) begin
			mem[i] = i[7:0] ^ i[15:8] ^ {7'b0, i[16]};
		end
		mem_din   = 8'h00;
		out_valid = 1'b0;
		out_byte  = 8'h00;
		stopped   = 1'b0;
	end

	always @(posedge clk_in) begin
		out_valid <= 1'b0;
		// read data follows the address by one active cycle
		if (rdy_in) begin
			mem_din <= is_io ? 8'h00 : mem[mem_a[16:0]];
		end
		if (mem_wr) begin
			if (!is_io) begin
				mem[mem_a[16:0]] <= mem_dout;
			end else if (mem_a == IO_OUT_ADDR) begin
				// zero bytes never reach the output stream
				if (mem_dout != 8'h00) begin
					out_valid <= 1'b1;
					out_byte  <= mem_dout;
				end
			end else if (mem_a == IO_STOP_ADDR) begin
				stopped <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam addr_t START_PC = 18'h00200;
	localparam int STOP_TIMEOUT = 20000;

	logic        clk_in;
	logic        reset;
	logic        rdy_in;
	logic [7:0]  mem_din;
	logic [7:0]  mem_dout;
	logic [31:0] mem_a;
	logic        mem_wr;
	logic        out_valid;
	logic [7:0]  out_byte;
	logic        stopped;

	logic        rdy_enable = 1'b0;
	logic        any_active = 1'b0;
	logic        first_checked = 1'b0;
	logic        was_frozen = 1'b0;
	logic [31:0] last_mem_a = 32'h0;
	logic [7:0]  exp_q [$];
	int          exp_pos = 0;
	int          pc_at;
	int          cycles;

	cpu #(.RESET_PC(START_PC)) dut0 (
		.clk_in(clk_in), .reset(reset), .rdy_in(rdy_in),
		.mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
	);

	ram_model ram0 (
		.clk_in(clk_in), .rdy_in(rdy_in), .mem_a(mem_a), .mem_dout(mem_dout),
		.mem_wr(mem_wr), .mem_din(mem_din),
		.out_valid(out_valid), .out_byte(out_byte), .stopped(stopped)
	);

	initial begin
		clk_in = 1'b0;
		forever #2 clk_in = ~clk_in;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// RV32I instruction formats
	function automatic word_t itype(input int imm, input int rs1, input int f3, input int rd,
		input opcode_t op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t rtype(input int f7, input int rs2, input int rs1, input int f3,
		input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
	endfunction

	function automatic word_t stype(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t btype(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic word_t utype(input int imm20, input int rd);
		return {imm20[19:0], rd[4:0], OP_LUI};
	endfunction

	function automatic word_t jtype(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
	endfunction

	function automatic word_t sign_extend12(input int v);
		return {{20{v[11]}}, v[11:0]};
	endfunction

	// little-endian instruction word at the next program address
	task automatic emit(input word_t w);
		ram0.mem[pc_at]     = w[7:0];
		ram0.mem[pc_at + 1] = w[15:8];
		ram0.mem[pc_at + 2] = w[23:16];
		ram0.mem[pc_at + 3] = w[31:24];
		pc_at += 4;
	endtask

	// store a register to the output port through the i/o base in x31
	task automatic out_store(input int rs, input word_t value);
		emit(stype(0, rs, 31));
		if (value[7:0] != 8'h00) begin
			exp_q.push_back(value[7:0]);
		end
	endtask

	task automatic out_plus_one(input int rs, input word_t value);
		emit(itype(1, rs, 0, 29, OP_IMM));
		out_store(29, value + 32'd1);
	endtask

	task automatic load_program();
		word_t va;
		word_t vb;
		word_t vc;
		word_t vd;
		int    link;
		va = sign_extend12(12'h5A3);
		vb = sign_extend12(12'hE39);
		vc = 32'h1234_5000;
		vd = vc + sign_extend12(12'h678);
		pc_at = START_PC;
		emit(utype(20'h00030, 31));
		emit(itype(12'h0EE, 0, 0, 30, OP_IMM));
		emit(itype(12'h041, 0, 0, 20, OP_IMM));
		emit(itype(12'h042, 0, 0, 21, OP_IMM));
		emit(itype(12'h5A3, 0, 0, 1, OP_IMM));
		out_plus_one(1, va);
		emit(itype(12'hE39, 0, 0, 2, OP_IMM));
		out_plus_one(2, vb);
		emit(rtype(7'h00, 2, 1, 3'b000, 3));
		out_plus_one(3, va + vb);
		emit(rtype(7'h20, 2, 1, 3'b000, 4));
		out_plus_one(4, va - vb);
		emit(rtype(7'h00, 2, 1, 3'b111, 5));
		out_plus_one(5, va & vb);
		emit(rtype(7'h00, 2, 1, 3'b110, 6));
		out_plus_one(6, va | vb);
		emit(rtype(7'h00, 2, 1, 3'b100, 7));
		out_plus_one(7, va ^ vb);
		emit(utype(20'h12345, 8));
		out_plus_one(8, vc);
		emit(itype(12'h678, 8, 0, 9, OP_IMM));
		out_plus_one(9, vd);
		emit(itype(12'h0F0, 9, 3'b111, 10, OP_IMM));
		out_plus_one(10, vd & sign_extend12(12'h0F0));
		emit(itype(12'h80C, 1, 3'b110, 11, OP_IMM));
		out_plus_one(11, va | sign_extend12(12'h80C));
		emit(itype(12'h7FF, 2, 3'b100, 12, OP_IMM));
		out_plus_one(12, vb ^ sign_extend12(12'h7FF));
		// word round trip through 0x100
		emit(stype(12'h100, 9, 0));
		emit(itype(12'h100, 0, 3'b010, 13, OP_LOAD));
		out_store(13, vd);
		// an offset load brings byte k of the stored word to the low lane
		emit(itype(12'h101, 0, 3'b010, 14, OP_LOAD));
		out_store(14, vd >> 8);
		emit(itype(12'h102, 0, 3'b010, 15, OP_LOAD));
		out_store(15, vd >> 16);
		emit(itype(12'h103, 0, 3'b010, 16, OP_LOAD));
		out_store(16, vd >> 24);
		// taken branches skip a poisoned store and untaken ones fall into a marker
		emit(btype(8, 9, 13, 3'b000));
		emit(stype(0, 30, 31));
		emit(btype(8, 9, 13, 3'b001));
		out_store(20, 32'h41);
		emit(btype(8, 0, 13, 3'b000));
		out_store(21, 32'h42);
		emit(btype(8, 0, 13, 3'b001));
		emit(stype(0, 30, 31));
		link = pc_at + 4;
		emit(jtype(8, 17));
		emit(stype(0, 30, 31));
		out_store(17, link);
		emit(stype(4, 0, 31));
		emit(jtype(0, 0));
	endtask

	// rdy_in is low about one cycle in four once enabled
	initial begin
		int unsigned seed;
		rdy_in = 1'b0;
		seed = $urandom(95701);
		forever begin
			@(posedge clk_in);
			rdy_in <= rdy_enable ? (($urandom % 4) != 0) : 1'b0;
		end
	end

	always @(posedge clk_in) begin
		if (!reset) begin
			if (!any_active) begin
				assert (mem_a == 32'h0) else
					fail_run($sformatf("Error: mem_a expected 0x%08h got 0x%08h", 32'h0, mem_a));
				assert (mem_wr == 1'b0) else
					fail_run($sformatf("Error: mem_wr expected 0x0 got 0x%0h", mem_wr));
				assert (mem_dout == 8'h00) else
					fail_run($sformatf("Error: mem_dout expected 0x00 got 0x%02h", mem_dout));
			end else if (!first_checked) begin
				assert (mem_a == {14'b0, START_PC}) else
					fail_run($sformatf("Error: mem_a expected 0x%08h got 0x%08h",
						{14'b0, START_PC}, mem_a));
				first_checked <= 1'b1;
			end
			if (rdy_in) begin
				any_active <= 1'b1;
			end else begin
				assert (mem_wr == 1'b0) else
					fail_run($sformatf("Error: mem_wr expected 0x0 got 0x%0h", mem_wr));
			end
			if (was_frozen) begin
				assert (mem_a == last_mem_a) else
					fail_run($sformatf("Error: mem_a expected 0x%08h got 0x%08h",
						last_mem_a, mem_a));
			end
			if (out_valid) begin
				if (exp_pos >= exp_q.size()) begin
					fail_run("the program wrote more output bytes than expected");
				end else begin
					assert (out_byte == exp_q[exp_pos]) else
						fail_run($sformatf("Error: out_byte expected 0x%02h got 0x%02h",
							exp_q[exp_pos], out_byte));
					exp_pos <= exp_pos + 1;
				end
			end
		end
		was_frozen <= !reset && !rdy_in;
		last_mem_a <= mem_a;
	end

	initial begin
		reset = 1'b1;
		#1;
		load_program();
		repeat (8) @(posedge clk_in);
		reset <= 1'b0;
		repeat (3) @(posedge clk_in);
		rdy_enable <= 1'b1;
		for (cycles = 0; cycles < STOP_TIMEOUT && !stopped; cycles++) begin
			@(posedge clk_in);
		end
		@(posedge clk_in);
		if (!stopped) begin
			fail_run("the program never reached the stop write before the timeout");
		end else if (exp_pos != exp_q.size()) begin
			fail_run($sformatf("Error: out_byte count expected 0x%0h got 0x%0h",
				exp_q.size(), exp_pos));
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: project.f
common/cpu_pkg.sv
core/alu.sv
core/regfile.sv
core/decoder.sv
core/mem_ctrl.sv
core/sequencer.sv
core/cpu.sv
tb/ram_model.sv
tb/tb_cpu.sv
